//--- testbench/motion_stimulus.txt
# W cmd_word | R addr mask expected | M dir duration rate accel hold
# E fwd_edges back_edges | F double edge | I wait idle and check model | Z phases off
R 1 000000ff 00000000   # status after reset
W fe000000              # version
R 0 ffffffff 00010200
W 0b000002              # tick every 3 clocks
W 0c000000              # full step
W 0a000001              # enable
M 1 00000014 00400000 00020000 0
M 0 00000010 00800000 fffe0000 0
M 1 00000018 00c00000 00010000 0
I
R 1 0000007f 00000040   # enabled, idle, empty
W 0a000000              # disable
Z
M 1 00000020 00600000 00000000 0
M 0 00000008 00400000 00000000 0
M 1 00000008 00800000 00000000 0
M 0 00000008 00300000 00010000 0
R 1 0000007f 00000014   # level 4 and full
W 0a000001
M 1 0000000c 00500000 00000000 0
M 0 0000000c 00700000 00000000 1
I
E 0000000a 00000003
R 2 ffffffff 00000007
F
R 1 00000080 00000080   # fault bit
W 0d000000              # zero position and count
R 2 ffffffff 00000000
R 3 ffffffff 00000000

//--- verilog.f
+incdir+rtl
rtl/motion_pkg.sv
rtl/move_if.sv
rtl/cmd_ctrl.sv
rtl/move_fifo.sv
rtl/dda_stepper.sv
rtl/quad_decoder.sv
rtl/hbridge_phaser.sv
rtl/motion_top.sv
testbench/tb_motion_top.sv

//--- testbench/tb_motion_top.sv
`default_nettype none

`include "motion_defs.svh"

module tb_motion_top;

  localparam int BUS_TIMEOUT  = 1000;  // Long enough for a held accel word
  localparam int IDLE_POLLS   = 500;
  localparam int EDGE_CLOCKS  = 5;

  logic        CLK;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat_w;
  wire  [31:0] wb_dat_r;
  wire         wb_ack;
  logic        enc_a;
  logic        enc_b;
  wire         step;
  wire         dir;
  wire         move_done;
  wire         buffer_ready;
  wire  [3:0]  phase;    // {a1, a2, b1, b2}
  wire  [3:0]  phase_h;

  int                 mismatches;
  int                 failures;
  bit                 abort;
  int                 fd;
  int                 n;
  int                 c;
  logic [7:0]         act;
  logic [31:0]        a0, a1, a2, a3, a4;
  logic [31:0]        rdata;

  // Reference model state
  logic signed [31:0] model_acc;
  int                 model_steps;
  logic signed [31:0] model_pos;
  bit                 dir_q[$];
  int                 step_count;
  int                 done_idx;
  logic               md_last;
  logic [4:0]         ref_idx;
  logic [1:0]         ms;
  bit                 phase_due;
  logic [1:0]         enc_idx;

  motion_top dut0 (
    .CLK(CLK), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .enc_a(enc_a), .enc_b(enc_b),
    .step(step), .dir(dir), .move_done(move_done), .buffer_ready(buffer_ready),
    .phase_a1(phase[3]), .phase_a2(phase[2]), .phase_b1(phase[1]), .phase_b2(phase[0]),
    .phase_a1_h(phase_h[3]), .phase_a2_h(phase_h[2]),
    .phase_b1_h(phase_h[1]), .phase_b2_h(phase_h[0])
  );

  always #2 CLK = ~CLK;

  // Two-phase-on full-step sequence by quadrant
  function automatic logic [3:0] full_step_pattern(input logic [1:0] quadrant);
    case (quadrant)
      2'd0:    return 4'b1010;
      2'd1:    return 4'b0110;
      2'd2:    return 4'b0101;
      default: return 4'b1001;
    endcase
  endfunction

  // Encoder levels {A, B} where A leads going forward
  function automatic logic [1:0] enc_levels(input logic [1:0] idx);
    case (idx)
      2'd0:    return 2'b00;
      2'd1:    return 2'b10;
      2'd2:    return 2'b11;
      default: return 2'b01;
    endcase
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic report_bad_line(input logic [7:0] code);
    $display("Stimulus action %c is missing operands", code);
    failures++;
    abort = 1;
  endtask

  task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] data,
                           output logic [31:0] rd);
    int waited;
    rd = '0;
    if (!abort) begin
      repeat ($urandom % 3) @(posedge CLK);  // Idle gap
      @(posedge CLK);
      #1;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = data;
      waited   = 0;
      while (!wb_ack && waited < BUS_TIMEOUT) begin
        @(posedge CLK);
        #1;
        waited++;
      end
      if (!wb_ack) begin
        $display("Wishbone cycle to address %0d got no ack within %0d clocks", adr, waited);
        failures++;
        abort = 1;
      end
      rd = wb_dat_r;
      @(posedge CLK);
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
    end
  endtask

  task automatic write_cmd(input logic [31:0] word);
    logic [31:0] unused;
    if (word[31:24] == motion_pkg::OPC_MICROSTEP) ms = word[1:0];
    if (word[31:24] == motion_pkg::OPC_ZERO_POS) model_pos = '0;
    bus_cycle(1'b1, `ADDR_CMD, word, unused);
  endtask

  // DDA rule per tick with the accumulator carried between moves
  task automatic run_move(input logic mdir, input logic [31:0] dur,
                          input logic signed [31:0] rate, input logic signed [31:0] accel,
                          input logic hold);
    logic signed [31:0] rate_m;
    logic [31:0]        unused;
    int                 steps;
    int                 done_before;
    int                 t;
    rate_m = rate;
    steps  = 0;
    for (t = 0; t < dur; t++) begin
      model_acc = model_acc + rate_m;
      if (model_acc >= `STEP_THRESHOLD) begin
        model_acc = model_acc - `STEP_THRESHOLD;
        steps++;
      end
      rate_m = rate_m + accel;
    end
    model_steps += steps;
    model_pos = mdir ? model_pos + steps : model_pos - steps;
    dir_q.push_back(mdir);
    bus_cycle(1'b1, `ADDR_CMD, {motion_pkg::OPC_MOVE, 23'd0, mdir}, unused);
    bus_cycle(1'b1, `ADDR_CMD, dur, unused);
    bus_cycle(1'b1, `ADDR_CMD, rate, unused);
    if (hold) check(buffer_ready, 1'b0, "buffer_ready before held accel word");
    done_before = done_idx;
    bus_cycle(1'b1, `ADDR_CMD, accel, unused);
    if (hold) check(done_idx > done_before, 1'b1, "accel ack only after a move ended");
  endtask

  task automatic wait_idle();
    logic [31:0] status;
    logic [31:0] pos;
    int          polls;
    polls = 0;
    bus_cycle(1'b0, `ADDR_STATUS, '0, status);
    while ((status & 32'h27) != 0 && polls < IDLE_POLLS && !abort) begin
      bus_cycle(1'b0, `ADDR_STATUS, '0, status);
      polls++;
    end
    if (!abort && (status & 32'h27) != 0) begin
      $display("Moves still running after %0d status polls", polls);
      failures++;
      abort = 1;
    end else if (!abort) begin
      check(step_count, model_steps, "step pulse count");
      check(done_idx, dir_q.size(), "completed moves");
      bus_cycle(1'b0, `ADDR_POS, '0, pos);
      check(pos, model_pos, "step position");
    end
  endtask

  task automatic drive_encoder(input int fwd, input int back);
    int k;
    for (k = 0; k < fwd + back; k++) begin
      enc_idx = (k < fwd) ? enc_idx + 2'd1 : enc_idx - 2'd1;
      {enc_a, enc_b} = enc_levels(enc_idx);
      repeat (EDGE_CLOCKS) @(posedge CLK);
      #1;
    end
  endtask

  task automatic double_edge();
    enc_idx = enc_idx + 2'd2;  // Both inputs flip together
    {enc_a, enc_b} = enc_levels(enc_idx);
    repeat (EDGE_CLOCKS) @(posedge CLK);
    #1;
  endtask

  // Step, dir and phase monitor sampled mid-cycle
  always @(negedge CLK) begin
    if (!reset) begin
      if (phase_due) begin
        check(phase, full_step_pattern(ref_idx[4:3]), "phase outputs after step");
        check(phase ^ phase_h, 4'hf, "low-side outputs inverse of high side");
        phase_due = 0;
      end
      if (move_done !== md_last) begin
        md_last = move_done;
        done_idx++;
      end
      if (step) begin
        step_count++;
        if (done_idx < dir_q.size()) begin
          check(dir, dir_q[done_idx], "dir while stepping");
          ref_idx = dir_q[done_idx] ? ref_idx + (5'd8 >> ms) : ref_idx - (5'd8 >> ms);
          phase_due = 1;
        end else begin
          $display("Step pulse at %0t while no move was queued", $time);
          failures++;
        end
      end
    end
  end

  initial begin
    CLK = 1'b0;
    reset = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = 2'd0;
    wb_dat_w = '0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    mismatches = 0;
    failures = 0;
    abort = 0;
    model_acc = '0;
    model_steps = 0;
    model_pos = '0;
    step_count = 0;
    done_idx = 0;
    md_last = 1'b0;
    ref_idx = '0;
    ms = 2'd0;
    phase_due = 0;
    enc_idx = 2'd0;
    void'($urandom(32'h1be9_759e));
    repeat (3) @(posedge CLK);
    #1 reset = 1'b0;

    fd = $fopen("testbench/motion_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/motion_stimulus.txt");
      failures++;
    end else begin
      while (!abort && $fscanf(fd, " %c", act) == 1) begin
        case (act)
          "#": begin
            c = $fgetc(fd);
            while (c != "\n" && c != -1) c = $fgetc(fd);
          end
          "W": begin
            n = $fscanf(fd, "%h", a0);
            if (n != 1) report_bad_line(act);
            else write_cmd(a0);
          end
          "R": begin
            n = $fscanf(fd, "%h %h %h", a0, a1, a2);
            if (n != 3) begin
              report_bad_line(act);
            end else begin
              bus_cycle(1'b0, a0[1:0], '0, rdata);
              check(rdata & a1, a2, $sformatf("read of address %0d", a0));
            end
          end
          "M": begin
            n = $fscanf(fd, "%h %h %h %h %h", a0, a1, a2, a3, a4);
            if (n != 5) report_bad_line(act);
            else run_move(a0[0], a1, a2, a3, a4[0]);
          end
          "E": begin
            n = $fscanf(fd, "%h %h", a0, a1);
            if (n != 2) report_bad_line(act);
            else drive_encoder(a0, a1);
          end
          "F": double_edge();
          "I": wait_idle();
          "Z": check({phase, phase_h}, 8'h0f, "phase outputs while disabled");
          default: begin
            $display("Unknown stimulus action code %c", act);
            failures++;
            abort = 1;
          end
        endcase
      end
      $fclose(fd);
    end

    $display("Run complete: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/motion_top.sv
`default_nettype none

`include "motion_defs.svh"

module motion_top (
  input  wire               CLK,
  input  wire               reset,
  input  wire               wb_cyc,
  input  wire               wb_stb,
  input  wire               wb_we,
  input  wire [1:0]         wb_adr,
  input  wire [`WORD_W-1:0] wb_dat_w,
  output wire [`WORD_W-1:0] wb_dat_r,
  output wire               wb_ack,
  input  wire               enc_a,
  input  wire               enc_b,
  output wire               step,
  output wire               dir,
  output wire               move_done,
  output wire               buffer_ready,
  output wire               phase_a1,
  output wire               phase_a2,
  output wire               phase_b1,
  output wire               phase_b2,
  output wire               phase_a1_h,
  output wire               phase_a2_h,
  output wire               phase_b1_h,
  output wire               phase_b2_h
);

  wire                     enable;
  wire [7:0]               clk_div;
  wire [1:0]               microstep;
  wire                     zero_pos;
  wire                     busy;
  wire signed [`POS_W-1:0] position;
  wire signed [`POS_W-1:0] enc_count;
  wire                     enc_fault;

  move_if mv_bus ();

  assign buffer_ready = ~mv_bus.full;

  // Low-side drive is the complement of the high side
  assign phase_a1_h = ~phase_a1;
  assign phase_a2_h = ~phase_a2;
  assign phase_b1_h = ~phase_b1;
  assign phase_b2_h = ~phase_b2;

  cmd_ctrl ctrl0 (
    .CLK(CLK), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .mv(mv_bus.ctrl),
    .enc_count(enc_count), .position(position), .enc_fault(enc_fault), .busy(busy),
    .enable(enable), .clk_div(clk_div), .microstep(microstep), .zero_pos(zero_pos)
  );

  move_fifo fifo0 (.CLK(CLK), .reset(reset), .mv(mv_bus.buffer));

  dda_stepper dda0 (
    .CLK(CLK), .reset(reset), .mv(mv_bus.exec),
    .enable(enable), .clk_div(clk_div), .zero_pos(zero_pos),
    .step(step), .dir(dir), .busy(busy), .move_done(move_done), .position(position)
  );

  quad_decoder enc0 (
    .CLK(CLK), .reset(reset), .enc_a(enc_a), .enc_b(enc_b), .zero_pos(zero_pos),
    .count(enc_count), .fault(enc_fault)
  );

  hbridge_phaser phaser0 (
    .CLK(CLK), .reset(reset), .step(step), .dir(dir), .enable(enable),
    .microstep(microstep),
    .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1), .phase_b2(phase_b2)
  );

endmodule

`default_nettype wire

//--- rtl/hbridge_phaser.sv
`default_nettype none

module hbridge_phaser (
  input  wire       CLK,
  input  wire       reset,
  input  wire       step,
  input  wire       dir,
  input  wire       enable,
  input  wire [1:0] microstep,
  output logic      phase_a1,
  output logic      phase_a2,
  output logic      phase_b1,
  output logic      phase_b2
);

  logic [4:0] phase_idx;
  logic [4:0] phase_inc;
  logic [3:0] pattern;  // {a1, a2, b1, b2}

  // Full step moves one quadrant, eighth step one index
  assign phase_inc = 5'd8 >> microstep;

  always_ff @(posedge CLK) begin
    if (reset) begin
      phase_idx <= 5'd0;
    end else if (step && enable) begin
      phase_idx <= dir ? phase_idx + phase_inc : phase_idx - phase_inc;
    end
  end

  // Two-phase-on sequence by quadrant
  always_comb begin
    case (phase_idx[4:3])
      2'd0:    pattern = 4'b1010;
      2'd1:    pattern = 4'b0110;
      2'd2:    pattern = 4'b0101;
      default: pattern = 4'b1001;
    endcase
  end

  assign phase_a1 = enable & pattern[3];
  assign phase_a2 = enable & pattern[2];
  assign phase_b1 = enable & pattern[1];
  assign phase_b2 = enable & pattern[0];

endmodule

`default_nettype wire

//--- rtl/quad_decoder.sv
`default_nettype none

`include "motion_defs.svh"

module quad_decoder (
  input  wire                      CLK,
  input  wire                      reset,
  input  wire                      enc_a,
  input  wire                      enc_b,
  input  wire                      zero_pos,
  output logic signed [`POS_W-1:0] count,
  output logic                     fault
);

  logic [1:0] a_sync;
  logic [1:0] b_sync;
  logic       a_prev;
  logic       b_prev;
  logic [3:0] trans;  // Previous and current A/B sample

  assign trans = {a_prev, b_prev, a_sync[1], b_sync[1]};

  always_ff @(posedge CLK) begin
    if (reset) begin
      a_sync <= 2'b00;
      b_sync <= 2'b00;
      a_prev <= 1'b0;
      b_prev <= 1'b0;
      count  <= '0;
      fault  <= 1'b0;
    end else begin
      a_sync <= {a_sync[0], enc_a};
      b_sync <= {b_sync[0], enc_b};
      a_prev <= a_sync[1];
      b_prev <= b_sync[1];

      if (zero_pos) begin
        count <= '0;
      end else begin
        case (trans)
          // A leads B
          4'b0010, 4'b1011, 4'b1101, 4'b0100: count <= count + 1'b1;
          // B leads A
          4'b0001, 4'b0111, 4'b1110, 4'b1000: count <= count - 1'b1;
          default: ;
        endcase
      end

      // Sticky fault when both inputs move in one sample
      case (trans)
        4'b0011, 4'b0110, 4'b1001, 4'b1100: fault <= 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/dda_stepper.sv
`default_nettype none

`include "motion_defs.svh"

module dda_stepper (
  input  wire                      CLK,
  input  wire                      reset,
  move_if.exec                     mv,
  input  wire                      enable,
  input  wire [7:0]                clk_div,
  input  wire                      zero_pos,
  output logic                     step,
  output logic                     dir,
  output logic                     busy,
  output logic                     move_done,
  output logic signed [`POS_W-1:0] position
);

  logic [7:0]                div_cnt;
  logic [`WORD_W-1:0]        dur_cnt;   // Ticks left in this move
  logic signed [`WORD_W-1:0] rate_r;
  logic signed [`WORD_W-1:0] accel_r;
  logic signed [`WORD_W-1:0] acc;
  logic signed [`WORD_W-1:0] acc_sum;
  logic                      load;
  logic                      tick;
  logic                      step_now;

  // New moves only start while enabled
  assign load   = ~busy & mv.avail & enable;
  assign mv.pop = load;

  assign tick     = busy & (dur_cnt != '0) & (div_cnt == 8'd0);
  assign acc_sum  = acc + rate_r;
  assign step_now = tick & (acc_sum >= `STEP_THRESHOLD);

  always_ff @(posedge CLK) begin
    if (reset) begin
      busy      <= 1'b0;
      step      <= 1'b0;
      move_done <= 1'b0;
      dir       <= 1'b0;
      div_cnt   <= 8'd0;
      dur_cnt   <= '0;
      acc       <= '0;
      position  <= '0;
    end else begin
      step <= step_now;
      if (load) begin
        busy    <= 1'b1;
        dir     <= mv.pop_rec.dir;
        dur_cnt <= mv.pop_rec.duration;
        div_cnt <= clk_div;
      end else if (busy) begin
        if (dur_cnt == '0) begin
          busy      <= 1'b0;
          move_done <= ~move_done;
        end else if (div_cnt != 8'd0) begin
          div_cnt <= div_cnt - 1'b1;
        end else begin
          div_cnt <= clk_div;
          dur_cnt <= dur_cnt - 1'b1;
          // Accumulator is never cleared between moves
          acc     <= step_now ? acc_sum - `STEP_THRESHOLD : acc_sum;
        end
      end

      if (zero_pos) begin
        position <= '0;
      end else if (step_now) begin
        position <= dir ? position + 1'b1 : position - 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (load) begin
      rate_r  <= mv.pop_rec.rate;
      accel_r <= mv.pop_rec.accel;
    end else if (tick) begin
      rate_r <= rate_r + accel_r;  // Rate ramps after it is applied
    end
  end

endmodule

`default_nettype wire

//--- rtl/move_fifo.sv
`default_nettype none

`include "motion_defs.svh"

module move_fifo (
  input  wire    CLK,
  input  wire    reset,
  move_if.buffer mv
);

  motion_pkg::move_t      mem [`MOVE_DEPTH];
  logic [`MOVE_PTR_W-1:0] wr_ptr;
  logic [`MOVE_PTR_W-1:0] rd_ptr;
  logic                   do_push;
  logic                   do_pop;

  assign do_push = mv.push & ~mv.full;
  assign do_pop  = mv.pop & mv.avail;

  assign mv.full    = (mv.level == `MOVE_DEPTH);
  assign mv.avail   = (mv.level != '0);
  assign mv.pop_rec = mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      mv.level <= '0;
    end else begin
      // Pointers wrap at the power-of-two depth
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   mv.level <= mv.level + 1'b1;
        2'b01:   mv.level <= mv.level - 1'b1;
        default: ;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= mv.push_rec;
    end
  end

  a_no_push_full: assert property (@(posedge CLK) disable iff (reset)
    mv.push |-> !mv.full);

  a_no_pop_empty: assert property (@(posedge CLK) disable iff (reset)
    mv.pop |-> mv.avail);

endmodule

`default_nettype wire

//--- rtl/cmd_ctrl.sv
`default_nettype none

`include "motion_defs.svh"

module cmd_ctrl (
  input  wire                     CLK,
  input  wire                     reset,
  input  wire                     wb_cyc,
  input  wire                     wb_stb,
  input  wire                     wb_we,
  input  wire [1:0]               wb_adr,
  input  wire [`WORD_W-1:0]       wb_dat_w,
  output logic [`WORD_W-1:0]      wb_dat_r,
  output logic                    wb_ack,
  move_if.ctrl                    mv,
  input  wire signed [`POS_W-1:0] enc_count,
  input  wire signed [`POS_W-1:0] position,
  input  wire                     enc_fault,
  input  wire                     busy,
  output logic                    enable,
  output logic [7:0]              clk_div,
  output logic [1:0]              microstep,
  output logic                    zero_pos
);

  motion_pkg::ctrl_state_e   state;
  motion_pkg::opcode_e       opcode;
  logic                      req;
  logic                      wr_cmd;
  logic [`WORD_W-1:0]        reply;
  logic [`WORD_W-1:0]        status_word;
  logic [`WORD_W-1:0]        rd_mux;
  logic                      mv_dir;
  logic [`WORD_W-1:0]        mv_duration;
  logic signed [`WORD_W-1:0] mv_rate;
  logic signed [`WORD_W-1:0] mv_accel;
  logic signed [`WORD_W-1:0] accel_word;

  // A request is seen once; ack blocks the repeat in the ack cycle
  assign req    = wb_cyc & wb_stb & ~wb_ack;
  assign wr_cmd = req & wb_we & (wb_adr == `ADDR_CMD);
  assign opcode = motion_pkg::opcode_e'(wb_dat_w[`WORD_W-1:`WORD_W-`OPC_W]);

  // Accel comes straight off the bus unless it had to wait
  assign accel_word = (state == motion_pkg::CS_PUSH) ? mv_accel : wb_dat_w;
  assign mv.push_rec = '{dir: mv_dir, duration: mv_duration, rate: mv_rate,
                         accel: accel_word};
  assign mv.push = ~mv.full & ((state == motion_pkg::CS_PUSH) |
                               (wr_cmd & (state == motion_pkg::CS_ACCEL)));

  always_comb begin
    status_word = '0;
    status_word[`MOVE_PTR_W:0] = mv.level;
    status_word[4] = mv.full;
    status_word[5] = busy;
    status_word[6] = enable;
    status_word[7] = enc_fault;
  end

  always_comb begin
    case (wb_adr)
      `ADDR_CMD:    rd_mux = reply;
      `ADDR_STATUS: rd_mux = status_word;
      `ADDR_ENC:    rd_mux = enc_count;
      `ADDR_POS:    rd_mux = position;
      default:      rd_mux = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      state     <= motion_pkg::CS_HEADER;
      wb_ack    <= 1'b0;
      enable    <= 1'b0;
      clk_div   <= 8'd0;
      microstep <= 2'd0;
      reply     <= '0;
      zero_pos  <= 1'b0;
    end else begin
      wb_ack   <= 1'b0;
      zero_pos <= 1'b0;
      if (mv.push) begin
        wb_ack <= 1'b1;
        state  <= motion_pkg::CS_HEADER;
      end else if (req && state != motion_pkg::CS_PUSH) begin
        if (wr_cmd && state == motion_pkg::CS_ACCEL) begin
          state <= motion_pkg::CS_PUSH;  // Held without ack while the buffer is full
        end else begin
          wb_ack <= 1'b1;
          if (wr_cmd) begin
            case (state)
              motion_pkg::CS_HEADER: begin
                case (opcode)
                  motion_pkg::OPC_MOVE: begin
                    state <= motion_pkg::CS_DURATION;
                    reply <= enc_count;  // Encoder snapshot at move start
                  end
                  motion_pkg::OPC_ENABLE:    enable    <= wb_dat_w[0];
                  motion_pkg::OPC_CLK_DIV:   clk_div   <= wb_dat_w[7:0];
                  motion_pkg::OPC_MICROSTEP: microstep <= wb_dat_w[1:0];
                  motion_pkg::OPC_ZERO_POS:  zero_pos  <= 1'b1;
                  motion_pkg::OPC_VERSION:
                    reply <= {8'h00, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};
                  default: ;  // NOP and unknown codes
                endcase
              end
              motion_pkg::CS_DURATION: state <= motion_pkg::CS_RATE;
              motion_pkg::CS_RATE:     state <= motion_pkg::CS_ACCEL;
              default: ;
            endcase
          end
        end
      end
    end
  end

  // Move words and read data
  always_ff @(posedge CLK) begin
    if (req) begin
      wb_dat_r <= rd_mux;
    end
    if (wr_cmd) begin
      if (state == motion_pkg::CS_HEADER) mv_dir <= wb_dat_w[0];
      if (state == motion_pkg::CS_DURATION) mv_duration <= wb_dat_w;
      if (state == motion_pkg::CS_RATE) mv_rate <= wb_dat_w;
      if (state == motion_pkg::CS_ACCEL) mv_accel <= wb_dat_w;
    end
  end

  a_single_ack: assert property (@(posedge CLK) disable iff (reset)
    wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

//--- rtl/move_if.sv
`default_nettype none

`include "motion_defs.svh"

interface move_if;

  logic                  push;
  motion_pkg::move_t     push_rec;
  logic                  full;
  logic [`MOVE_PTR_W:0]  level;     // 0 up to MOVE_DEPTH entries
  motion_pkg::move_t     pop_rec;   // Head of the buffer
  logic                  avail;
  logic                  pop;

  // Command side
  modport ctrl (
    output push, push_rec,
    input  full, level
  );

  // Storage side
  modport buffer (
    input  push, push_rec, pop,
    output full, level, pop_rec, avail
  );

  // Step generator side
  modport exec (
    input  pop_rec, avail,
    output pop
  );

endinterface

`default_nettype wire

//--- rtl/motion_pkg.sv
`default_nettype none

`include "motion_defs.svh"

package motion_pkg;

  // Header opcodes in bits 31..24 of a command word
  typedef enum logic [`OPC_W-1:0] {
    OPC_NOP       = 8'h00,
    OPC_MOVE      = 8'h01,  // Followed by duration, rate, accel words
    OPC_ENABLE    = 8'h0a,
    OPC_CLK_DIV   = 8'h0b,
    OPC_MICROSTEP = 8'h0c,
    OPC_ZERO_POS  = 8'h0d,
    OPC_VERSION   = 8'hfe
  } opcode_e;

  // Command word sequencing
  typedef enum logic [2:0] {
    CS_HEADER,
    CS_DURATION,
    CS_RATE,
    CS_ACCEL,
    CS_PUSH     // Accel word held until the buffer has room
  } ctrl_state_e;

  // One buffered move
  typedef struct packed {
    logic                      dir;
    logic [`WORD_W-1:0]        duration;  // Ticks
    logic signed [`WORD_W-1:0] rate;
    logic signed [`WORD_W-1:0] accel;
  } move_t;

endpackage

`default_nettype wire

//--- rtl/motion_defs.svh
`ifndef MOTION_DEFS_SVH
`define MOTION_DEFS_SVH

// Host word and command header layout
`define WORD_W 32
`define OPC_W 8

// Move buffer
`define MOVE_DEPTH 4
`define MOVE_PTR_W 2

// Step position and encoder count
`define POS_W 32
`define STEP_THRESHOLD 32'sh0100_0000

`define VERSION_MAJOR 8'd1
`define VERSION_MINOR 8'd2
`define VERSION_PATCH 8'd0

// Wishbone word addresses
`define ADDR_CMD 2'd0
`define ADDR_STATUS 2'd1
`define ADDR_ENC 2'd2
`define ADDR_POS 2'd3

`endif
